// File: design/memAlign_defines.svh
`ifndef MEM_ALIGN_DEFINES_SVH
`define MEM_ALIGN_DEFINES_SVH

// cache line geometry
`define LINE_BYTES 16

// fully associative TLB depth
`define TLB_ENTRIES 8

// virtual address split, 4 KB pages
`define VADDR_W 32
`define PAGE_OFF_W 12
`define PFN_W 20

// widest single access
`define DATA_BYTES 8

`endif

// File: design/memAlignPkg.sv
`include "memAlign_defines.svh"

package memAlignPkg;

    // derived address field widths
    localparam int LINE_OFF_W = $clog2(`LINE_BYTES);
    localparam int LINE_ADDR_W = `VADDR_W - LINE_OFF_W;
    localparam int PAGE_LINE_W = `PAGE_OFF_W - LINE_OFF_W;
    localparam int VPN_W = `VADDR_W - `PAGE_OFF_W;
    localparam int TLB_IDX_W = $clog2(`TLB_ENTRIES);

    typedef enum logic [1:0] {
        SZ1 = 2'd0,
        SZ2 = 2'd1,
        SZ4 = 2'd2,
        SZ8 = 2'd3
    } accSize_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } memOp_e;

    typedef enum logic [1:0] {
        FLT_NONE = 2'd0,
        FLT_MISS = 2'd1,
        FLT_PROT = 2'd2
    } fault_e;

    typedef struct packed {
        logic [`VADDR_W-1:0]      vAddr;
        accSize_e                 size;
        memOp_e                   op;
        logic [`DATA_BYTES*8-1:0] data;
    } memReq_t;

    typedef struct packed {
        logic              valid;
        logic [VPN_W-1:0]  vpn;
        logic [`PFN_W-1:0] pfn;
        logic              writable;
        logic              uncached;
    } tlbEntry_t;

    typedef struct packed {
        logic              hit;
        logic [`PFN_W-1:0] pfn;
        logic              writable;
        logic              uncached;
    } tlbResult_t;

    // one line-sized piece of an access
    typedef struct packed {
        logic [LINE_ADDR_W-1:0]   pLine;
        logic [`LINE_BYTES-1:0]   mask;
        logic [`LINE_BYTES*8-1:0] data;
    } lineHalf_t;

    typedef struct packed {
        lineHalf_t half0;
        lineHalf_t half1;
        logic      needSecond;
        logic      uncached;
        fault_e    fault;
        memOp_e    op;
    } alignRsp_t;

endpackage

// File: design/lineSplitter.sv
`timescale 1ns/10ps
`include "memAlign_defines.svh"

module lineSplitter (
    input  logic [`VADDR_W-1:0]                   vAddr,
    input  memAlignPkg::accSize_e                 size,
    output logic [memAlignPkg::LINE_OFF_W-1:0]    offset,
    output logic [memAlignPkg::LINE_OFF_W-1:0]    byteCount,
    output logic                                  needSecond,
    output logic [memAlignPkg::LINE_ADDR_W-1:0]   secondLine,
    output logic [memAlignPkg::LINE_OFF_W-1:0]    tailBytes
);
    import memAlignPkg::*;

    // one extra bit so the end position can reach past the line
    logic [LINE_OFF_W:0] endSum;

    // size code to byte count
    always_comb begin
        unique case (size)
            SZ1: byteCount = 4'd1;
            SZ2: byteCount = 4'd2;
            SZ4: byteCount = 4'd4;
            SZ8: byteCount = 4'd8;
            default: byteCount = 4'd1;
        endcase
    end

    assign offset = vAddr[LINE_OFF_W-1:0];

    assign endSum = {1'b0, offset} + {1'b0, byteCount};

    // ending exactly on the boundary still fits in one line
    assign needSecond = endSum > `LINE_BYTES;

    // spill count is endSum minus the line size, i.e. the low bits
    assign tailBytes = needSecond ? endSum[LINE_OFF_W-1:0] : '0;

    // next virtual line, may wrap into the next page
    assign secondLine = vAddr[`VADDR_W-1:LINE_OFF_W] + 1'b1;

endmodule

// File: design/byteLaneShifter.sv
`timescale 1ns/10ps
`include "memAlign_defines.svh"

module byteLaneShifter (
    input  logic [memAlignPkg::LINE_OFF_W-1:0] offset,
    input  logic [memAlignPkg::LINE_OFF_W-1:0] byteCount,
    input  logic [memAlignPkg::LINE_OFF_W-1:0] tailBytes,
    input  logic                               needSecond,
    input  logic [`DATA_BYTES*8-1:0]           data,
    output logic [`LINE_BYTES-1:0]             mask0,
    output logic [`LINE_BYTES-1:0]             mask1,
    output logic [`LINE_BYTES*8-1:0]           data0,
    output logic [`LINE_BYTES*8-1:0]           data1
);
    import memAlignPkg::*;

    localparam logic [LINE_OFF_W:0] LINE_SPAN = `LINE_BYTES;
    localparam logic [`LINE_BYTES-1:0] LANE_ONE = 1;

    logic [`LINE_BYTES-1:0]   runMask;
    logic [`LINE_BYTES-1:0]   tailMask;
    logic [`LINE_BYTES*8-1:0] wideData;
    logic [LINE_OFF_W:0]      backShift;

    // data zero-extended to a full line
    assign wideData = {{(`LINE_BYTES - `DATA_BYTES)*8{1'b0}}, data};

    // run of byteCount ones at lane 0
    assign runMask = (LANE_ONE << byteCount) - 1'b1;

    // half 0 lanes start at the offset, upper bytes fall off the top
    assign mask0 = runMask << offset;
    assign data0 = wideData << {offset, 3'b000};

    // bytes that spilled over land at lane 0 of the next line
    assign backShift = LINE_SPAN - {1'b0, offset};
    assign tailMask = (LANE_ONE << tailBytes) - 1'b1;

    always_comb begin
        if (needSecond) begin
            mask1 = tailMask;
            data1 = wideData >> {backShift, 3'b000};
        end else begin
            mask1 = '0;
            data1 = '0;
        end
    end

endmodule

// File: design/tlbTable.sv
`timescale 1ns/10ps
`include "memAlign_defines.svh"

module tlbTable (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               wrEn,
    input  logic [memAlignPkg::TLB_IDX_W-1:0]  wrIndex,
    input  memAlignPkg::tlbEntry_t             wrEntry,
    input  logic [memAlignPkg::VPN_W-1:0]      vpn0,
    input  logic [memAlignPkg::VPN_W-1:0]      vpn1,
    output memAlignPkg::tlbResult_t            res0,
    output memAlignPkg::tlbResult_t            res1
);
    import memAlignPkg::*;

    tlbEntry_t entries [`TLB_ENTRIES];

    // write port, only the valid bits are cleared on reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (wrEn) begin
            entries[wrIndex] <= wrEntry;
        end
    end

    // scan from the top down so the lowest matching index ends up in res
    function automatic tlbResult_t lookup(input logic [VPN_W-1:0] vpn);
        tlbResult_t res;
        res = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].valid && (entries[i].vpn == vpn)) begin
                res.hit = 1'b1;
                res.pfn = entries[i].pfn;
                res.writable = entries[i].writable;
                res.uncached = entries[i].uncached;
            end
        end
        return res;
    endfunction

    // two independent read ports on the same array
    always_comb begin
        res0 = lookup(vpn0);
    end

    always_comb begin
        res1 = lookup(vpn1);
    end

endmodule

// File: design/inputAlign.sv
`timescale 1ns/10ps

module inputAlign (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           reqValid,
    input  memAlignPkg::memReq_t           req,
    output logic                           reqReady,
    output logic                           rspValid,
    output memAlignPkg::alignRsp_t         rsp,
    input  logic                           rspReady,
    output logic [memAlignPkg::VPN_W-1:0]  lookupVpn0,
    output logic [memAlignPkg::VPN_W-1:0]  lookupVpn1,
    input  memAlignPkg::tlbResult_t        lookupRes0,
    input  memAlignPkg::tlbResult_t        lookupRes1
);
    import memAlignPkg::*;

    logic [LINE_OFF_W-1:0]  offset;
    logic [LINE_OFF_W-1:0]  byteCount;
    logic [LINE_OFF_W-1:0]  tailBytes;
    logic                   needSecond;
    logic [LINE_ADDR_W-1:0] secondLine;
    logic [LINE_ADDR_W-1:0] firstLine;
    alignRsp_t              nextRsp;
    logic                   prot0;
    logic                   prot1;

    lineSplitter splitter_i (
        .vAddr      (req.vAddr),
        .size       (req.size),
        .offset     (offset),
        .byteCount  (byteCount),
        .needSecond (needSecond),
        .secondLine (secondLine),
        .tailBytes  (tailBytes)
    );

    byteLaneShifter shifter_i (
        .offset     (offset),
        .byteCount  (byteCount),
        .tailBytes  (tailBytes),
        .needSecond (needSecond),
        .data       (req.data),
        .mask0      (nextRsp.half0.mask),
        .mask1      (nextRsp.half1.mask),
        .data0      (nextRsp.half0.data),
        .data1      (nextRsp.half1.data)
    );

    assign firstLine = req.vAddr[LINE_OFF_W +: LINE_ADDR_W];

    // page numbers for both halves go out to the TLB
    assign lookupVpn0 = firstLine[LINE_ADDR_W-1:PAGE_LINE_W];
    assign lookupVpn1 = secondLine[LINE_ADDR_W-1:PAGE_LINE_W];

    // frame plus line-in-page, zero on a miss
    assign nextRsp.half0.pLine = lookupRes0.hit ?
        {lookupRes0.pfn, firstLine[PAGE_LINE_W-1:0]} : '0;
    assign nextRsp.half1.pLine = lookupRes1.hit ?
        {lookupRes1.pfn, secondLine[PAGE_LINE_W-1:0]} : '0;

    assign nextRsp.needSecond = needSecond;
    assign nextRsp.op = req.op;
    assign nextRsp.uncached = lookupRes0.uncached | (needSecond & lookupRes1.uncached);

    // write to a page without write permission
    assign prot0 = !lookupRes0.writable;
    assign prot1 = needSecond && !lookupRes1.writable;

    // miss outranks protection
    always_comb begin
        if (!lookupRes0.hit || (needSecond && !lookupRes1.hit)) begin
            nextRsp.fault = FLT_MISS;
        end else if ((req.op == OP_WRITE) && (prot0 || prot1)) begin
            nextRsp.fault = FLT_PROT;
        end else begin
            nextRsp.fault = FLT_NONE;
        end
    end

    // single slot, accepts when empty or draining this cycle
    assign reqReady = !rspValid || rspReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rspValid <= 1'b0;
        end else if (reqReady) begin
            rspValid <= reqValid;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            rsp <= nextRsp;
        end
    end

endmodule

// File: design/memAccessAlign.sv
`timescale 1ns/10ps

module memAccessAlign (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               reqValid,
    input  memAlignPkg::memReq_t               req,
    output logic                               reqReady,
    output logic                               rspValid,
    output memAlignPkg::alignRsp_t             rsp,
    input  logic                               rspReady,
    input  logic                               tlbWrEn,
    input  logic [memAlignPkg::TLB_IDX_W-1:0]  tlbWrIndex,
    input  memAlignPkg::tlbEntry_t             tlbWrEntry
);
    import memAlignPkg::*;

    // translation path between the align stage and the TLB
    logic [VPN_W-1:0] lookupVpn0;
    logic [VPN_W-1:0] lookupVpn1;
    tlbResult_t       lookupRes0;
    tlbResult_t       lookupRes1;

    inputAlign align_i (
        .clk        (clk),
        .rstN       (rstN),
        .reqValid   (reqValid),
        .req        (req),
        .reqReady   (reqReady),
        .rspValid   (rspValid),
        .rsp        (rsp),
        .rspReady   (rspReady),
        .lookupVpn0 (lookupVpn0),
        .lookupVpn1 (lookupVpn1),
        .lookupRes0 (lookupRes0),
        .lookupRes1 (lookupRes1)
    );

    tlbTable tlb_i (
        .clk     (clk),
        .rstN    (rstN),
        .wrEn    (tlbWrEn),
        .wrIndex (tlbWrIndex),
        .wrEntry (tlbWrEntry),
        .vpn0    (lookupVpn0),
        .vpn1    (lookupVpn1),
        .res0    (lookupRes0),
        .res1    (lookupRes1)
    );

endmodule

// File: tb/memAccessAlign_chk.sv
`timescale 1ns/10ps

module memAccessAlign_chk (
    input logic                   clk,
    input logic                   rstN,
    input logic                   reqReady,
    input logic                   rspValid,
    input logic                   rspReady,
    input memAlignPkg::alignRsp_t rsp
);
    int failCount = 0;

    // held response stays put until it drains
    assert property (@(posedge clk) disable iff (!rstN)
        rspValid && !rspReady |=> rspValid && $stable(rsp))
        else begin
            failCount++;
            $error("response changed or dropped while stalled");
        end

    assert property (@(posedge clk) disable iff (!rstN)
        reqReady == (!rspValid || rspReady))
        else begin
            failCount++;
            $error("reqReady does not follow the output register state");
        end

    // single-line access leaves half 1 empty
    assert property (@(posedge clk) disable iff (!rstN)
        rspValid && !rsp.needSecond |-> rsp.half1.mask == '0)
        else begin
            failCount++;
            $error("half1 mask set without a second half");
        end

    assert property (@(posedge clk) !rstN |=> !rspValid)
        else begin
            failCount++;
            $error("rspValid high right after reset");
        end

endmodule

bind memAccessAlign memAccessAlign_chk chk_i (.*);

// File: tb/memAccessAlign_tb.sv
`timescale 1ns/10ps
`include "memAlign_defines.svh"

module memAccessAlign_tb;
    import memAlignPkg::*;

    localparam int NUM_ROWS = 14;
    localparam int REWRITE_AT = 13;
    localparam int CYCLE_LIMIT = 20 * NUM_ROWS + 100;

    // one request plus the expected flags for it
    typedef struct packed {
        logic [31:0] vAddr;
        accSize_e    size;
        memOp_e      op;
        logic [63:0] data;
        logic        needSecond;
        fault_e      fault;
        logic        uncached;
    } reqRow_t;

    logic                   clk;
    logic                   rstN;
    logic                   reqValid;
    memReq_t                req;
    logic                   reqReady;
    logic                   rspValid;
    alignRsp_t              rsp;
    logic                   rspReady;
    logic                   tlbWrEn;
    logic [TLB_IDX_W-1:0]   tlbWrIndex;
    tlbEntry_t              tlbWrEntry;

    reqRow_t   rows [NUM_ROWS];
    int        nRows;
    tlbEntry_t model [`TLB_ENTRIES];
    alignRsp_t expQ [$];
    int        rowQ [$];
    alignRsp_t curExp;
    int        curRow;
    int        errors;
    int        received;
    int        cycles;

    memAccessAlign dut_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // roughly 70 % ready
    initial begin
        void'($urandom(59650));
        forever begin
            @(posedge clk);
            rspReady <= ($urandom % 100) < 70;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles, %0d of %0d responses seen",
                     cycles, received, NUM_ROWS);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic tlbEntry_t makeEntry(input logic [19:0] vpn, input logic [19:0] pfn,
                                            input logic writable, input logic uncached);
        tlbEntry_t e;
        e.valid = 1'b1;
        e.vpn = vpn;
        e.pfn = pfn;
        e.writable = writable;
        e.uncached = uncached;
        return e;
    endfunction

    // first valid match wins, all zero on a miss
    function automatic tlbEntry_t matchEntry(input logic [19:0] vpn);
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (model[i].valid && model[i].vpn == vpn) begin
                return model[i];
            end
        end
        return '0;
    endfunction

    // lanes placed byte by byte, bytes past the line go to half 1
    function automatic alignRsp_t expectedRsp(input reqRow_t r);
        alignRsp_t e;
        int        offset;
        int        bytes;
        int        pos;
        logic [27:0] line1;
        tlbEntry_t ent0;
        tlbEntry_t ent1;
        e = '0;
        offset = r.vAddr[3:0];
        case (r.size)
            SZ1: bytes = 1;
            SZ2: bytes = 2;
            SZ4: bytes = 4;
            default: bytes = 8;
        endcase
        for (int b = 0; b < bytes; b++) begin
            pos = offset + b;
            if (pos < `LINE_BYTES) begin
                e.half0.mask[pos] = 1'b1;
                e.half0.data[pos*8 +: 8] = r.data[b*8 +: 8];
            end else begin
                e.half1.mask[pos-`LINE_BYTES] = 1'b1;
                e.half1.data[(pos-`LINE_BYTES)*8 +: 8] = r.data[b*8 +: 8];
            end
        end
        ent0 = matchEntry(r.vAddr[31:12]);
        line1 = r.vAddr[31:4] + 28'd1;
        ent1 = matchEntry(line1[27:8]);
        e.half0.pLine = ent0.valid ? {ent0.pfn, r.vAddr[11:4]} : '0;
        e.half1.pLine = ent1.valid ? {ent1.pfn, line1[7:0]} : '0;
        e.needSecond = r.needSecond;
        e.fault = r.fault;
        e.uncached = r.uncached;
        e.op = r.op;
        return e;
    endfunction

    task automatic addRow(input logic [31:0] vAddr, input accSize_e size, input memOp_e op,
                          input logic [63:0] data, input logic needSecond,
                          input fault_e fault, input logic uncached);
        rows[nRows] = {vAddr, size, op, data, needSecond, fault, uncached};
        nRows++;
    endtask

    task automatic writeTlb(input int idx, input tlbEntry_t ent);
        @(posedge clk);
        tlbWrEn <= 1'b1;
        tlbWrIndex <= idx[TLB_IDX_W-1:0];
        tlbWrEntry <= ent;
        @(posedge clk);
        tlbWrEn <= 1'b0;
        model[idx] = ent;
    endtask

    // returns at the negedge just before the transfer edge
    task automatic sendRow(input int idx);
        memReq_t r;
        r.vAddr = rows[idx].vAddr;
        r.size = rows[idx].size;
        r.op = rows[idx].op;
        r.data = rows[idx].data;
        @(posedge clk);
        reqValid <= 1'b1;
        req <= r;
        @(negedge clk);
        while (!reqReady) begin
            @(negedge clk);
        end
        expQ.push_back(expectedRsp(rows[idx]));
        rowQ.push_back(idx);
    endtask

    task automatic checkField(input int row, input string name,
                              input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error row %0d %s: got 0x%h, expected 0x%h", row, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (rstN && rspValid && rspReady) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("a response arrived with no request pending");
            end else begin
                curExp = expQ.pop_front();
                curRow = rowQ.pop_front();
                checkField(curRow, "half0.pLine", rsp.half0.pLine, curExp.half0.pLine);
                checkField(curRow, "half0.mask", rsp.half0.mask, curExp.half0.mask);
                checkField(curRow, "half0.data", rsp.half0.data, curExp.half0.data);
                checkField(curRow, "half1.pLine", rsp.half1.pLine, curExp.half1.pLine);
                checkField(curRow, "half1.mask", rsp.half1.mask, curExp.half1.mask);
                checkField(curRow, "half1.data", rsp.half1.data, curExp.half1.data);
                checkField(curRow, "needSecond", rsp.needSecond, curExp.needSecond);
                checkField(curRow, "uncached", rsp.uncached, curExp.uncached);
                checkField(curRow, "fault", rsp.fault, curExp.fault);
                checkField(curRow, "op", rsp.op, curExp.op);
                received++;
            end
        end
    end

    initial begin
        rstN = 1'b0;
        reqValid = 1'b0;
        req = '0;
        rspReady = 1'b0;
        tlbWrEn = 1'b0;
        tlbWrIndex = '0;
        tlbWrEntry = '0;
        errors = 0;
        received = 0;
        cycles = 0;
        nRows = 0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            model[i] = '0;
        end

        // aligned and in-line accesses
        addRow(32'h0001_0000, SZ1, OP_WRITE, 64'hA5, 1'b0, FLT_NONE, 1'b0);
        addRow(32'h0001_0002, SZ2, OP_READ, 64'h1234, 1'b0, FLT_NONE, 1'b0);
        // next line sits in the uncached page but is not used
        addRow(32'h0002_FFF4, SZ4, OP_WRITE, 64'hDEAD_BEEF, 1'b0, FLT_NONE, 1'b0);
        addRow(32'h0001_0008, SZ8, OP_WRITE, 64'h0123_4567_89AB_CDEF, 1'b0, FLT_NONE, 1'b0);
        // line crossings, the last one into the adjacent page
        addRow(32'h0001_000C, SZ8, OP_WRITE, 64'h1122_3344_5566_7788, 1'b1, FLT_NONE, 1'b0);
        addRow(32'h0001_004F, SZ2, OP_WRITE, 64'hBEEF, 1'b1, FLT_NONE, 1'b0);
        addRow(32'h0001_0FFA, SZ8, OP_WRITE, 64'hCAFE_F00D_1234_5678, 1'b1, FLT_NONE, 1'b0);
        // misses, second one only on half 1
        addRow(32'h0006_0000, SZ4, OP_READ, 64'h0, 1'b0, FLT_MISS, 1'b0);
        addRow(32'h0004_0FFE, SZ4, OP_READ, 64'h0, 1'b1, FLT_MISS, 1'b0);
        // read-only page, the read has an unmapped but unused next line
        addRow(32'h0002_0010, SZ4, OP_WRITE, 64'h55AA_55AA, 1'b0, FLT_PROT, 1'b0);
        addRow(32'h0002_0FF0, SZ4, OP_READ, 64'h0, 1'b0, FLT_NONE, 1'b0);
        // uncached page, directly and through half 1
        addRow(32'h0003_0020, SZ8, OP_READ, 64'h0, 1'b0, FLT_NONE, 1'b1);
        addRow(32'h0002_FFFC, SZ8, OP_WRITE, 64'h0F0E_0D0C_0B0A_0908, 1'b1, FLT_NONE, 1'b1);
        // after entry 2 is remapped as writable
        addRow(32'h0002_0010, SZ4, OP_WRITE, 64'h600D_F00D, 1'b0, FLT_NONE, 1'b0);

        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        writeTlb(0, makeEntry(20'h00010, 20'hA0010, 1'b1, 1'b0));
        writeTlb(1, makeEntry(20'h00011, 20'hB2345, 1'b1, 1'b0));
        writeTlb(2, makeEntry(20'h00020, 20'h0C001, 1'b0, 1'b0));
        writeTlb(3, makeEntry(20'h00030, 20'h55555, 1'b1, 1'b1));
        writeTlb(4, makeEntry(20'h00040, 20'h12340, 1'b1, 1'b0));
        writeTlb(5, makeEntry(20'h0002F, 20'h33333, 1'b1, 1'b0));

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i == REWRITE_AT) begin
                @(posedge clk);
                reqValid <= 1'b0;
                writeTlb(2, makeEntry(20'h00020, 20'h0D00E, 1'b1, 1'b0));
            end
            sendRow(i);
        end
        @(posedge clk);
        reqValid <= 1'b0;

        while (received < NUM_ROWS) begin
            @(posedge clk);
        end
        // a few idle cycles to catch stray responses
        repeat (4) @(posedge clk);
        errors += dut_i.chk_i.failCount;

        $display("errors: %0d, responses: %0d of %0d", errors, received, NUM_ROWS);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+design
design/memAlignPkg.sv
design/lineSplitter.sv
design/byteLaneShifter.sv
design/tlbTable.sv
design/inputAlign.sv
design/memAccessAlign.sv
tb/memAccessAlign_chk.sv
tb/memAccessAlign_tb.sv

// File: Bender.yml
package:
  name: mem_access_align

sources:
  - include_dirs:
      - design
    files:
      - design/memAlignPkg.sv
      - design/lineSplitter.sv
      - design/byteLaneShifter.sv
      - design/tlbTable.sv
      - design/inputAlign.sv
      - design/memAccessAlign.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/memAccessAlign_chk.sv
      - tb/memAccessAlign_tb.sv
